// File: adc5g_macros.svh
// bus address window, serial field widths, divider, buffer depth and
// reset hold count for the ADC5G controller
`ifndef ADC5G_MACROS_SVH
`define ADC5G_MACROS_SVH

// ==========================================================
// bus window
// ==========================================================
`define ADC5G_BASEADDR 32'h0000_0000
`define ADC5G_HIGHADDR 32'h0000_FFFF

// ==========================================================
// serial interface and buffering
// ==========================================================
`define ADC5G_SPI_ADDR_W 8
`define ADC5G_SPI_DATA_W 16
`define ADC5G_SCLK_DIV_W 5
`define ADC5G_FIFO_DEPTH 4

// hold counter width, the hold count is all ones
`define ADC5G_RST_HOLD_W 8

`endif

// File: adc5g_pkg.sv
// shared types: ADC register address and value, serial frame,
// bus register index and the register index values
`include "adc5g_macros.svh"

package adc5g_pkg;

  typedef logic [`ADC5G_SPI_ADDR_W-1:0] spi_addr_t;  // ADC register address
  typedef logic [`ADC5G_SPI_DATA_W-1:0] spi_data_t;  // ADC register value

  // address sits in the upper bits so it leaves the shifter first
  typedef struct packed {
    spi_addr_t addr;
    spi_data_t data;
  } spi_frame_t;

  typedef logic [1:0] reg_index_t;  // word select from address bits 3:2

  // ==========================================================
  // register map
  // ==========================================================
  localparam reg_index_t REG_CTRL = 2'd0;  // reset and phase shift
  localparam reg_index_t REG_CFG0 = 2'd1;  // channel 0 configuration
  localparam reg_index_t REG_CFG1 = 2'd2;  // channel 1 configuration
  localparam reg_index_t REG_ZERO = 2'd3;  // reads as zero

endpackage

// File: opb_adc5g_regs.sv
// OPB slave for the ADC5G controller: address decode, control and
// configuration registers, one-cycle strobes and readback mux
`timescale 1ns/1ns
`include "adc5g_macros.svh"

module opb_adc5g_regs (
  input  logic                  OPB_Clk,
  input  logic                  arst_n,
  input  logic [0:31]           opb_abus,
  input  logic [0:3]            opb_be,
  input  logic [0:31]           opb_dbus,
  input  logic                  opb_rnw,
  input  logic                  opb_select,
  input  logic                  adc0_psdone,
  input  logic                  adc1_psdone,
  input  logic                  busy0,
  input  logic                  busy1,
  input  logic                  ovf0,
  input  logic                  ovf1,
  output logic [0:31]           sl_dbus,
  output logic                  sl_xferack,
  output logic                  adc0_rst_req,
  output logic                  adc1_rst_req,
  output logic                  adc0_psen,
  output logic                  adc0_psincdec,
  output logic                  adc1_psen,
  output logic                  adc1_psincdec,
  output logic                  cfg0_push,
  output adc5g_pkg::spi_frame_t cfg0_frame,
  output logic                  cfg1_push,
  output adc5g_pkg::spi_frame_t cfg1_frame,
  output logic                  ovf0_clear,
  output logic                  ovf1_clear
);

  logic [31:0]            offset;
  logic                   addr_hit;
  logic                   take;
  logic                   wr_take;
  adc5g_pkg::reg_index_t  idx;
  adc5g_pkg::reg_index_t  rd_idx;
  logic [1:0]             wr_cfg;
  logic [1:0]             start_q;
  logic [1:0]             clear_q;
  adc5g_pkg::spi_addr_t   cfg_addr [2];
  adc5g_pkg::spi_data_t   cfg_data [2];
  logic [0:31]            rd_word;

  // ==========================================================
  // decode
  // ==========================================================
  assign addr_hit = (opb_abus >= `ADC5G_BASEADDR) && (opb_abus <= `ADC5G_HIGHADDR);
  assign offset   = opb_abus - `ADC5G_BASEADDR;  // bus bit 31 lands on offset[0]
  assign idx      = offset[3:2];
  assign take     = opb_select && addr_hit && !sl_xferack;  // one access every second cycle
  assign wr_take  = take && !opb_rnw;
  assign wr_cfg[0] = wr_take && (idx == adc5g_pkg::REG_CFG0);
  assign wr_cfg[1] = wr_take && (idx == adc5g_pkg::REG_CFG1);

  // ==========================================================
  // registers and strobes
  // ==========================================================
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      sl_xferack    <= 1'b0;
      rd_idx        <= adc5g_pkg::REG_CTRL;
      adc0_rst_req  <= 1'b0;
      adc1_rst_req  <= 1'b0;
      adc0_psen     <= 1'b0;
      adc1_psen     <= 1'b0;
      adc0_psincdec <= 1'b0;
      adc1_psincdec <= 1'b0;
      start_q       <= 2'b00;
      clear_q       <= 2'b00;
      for (int ch = 0; ch < 2; ch++) begin
        cfg_addr[ch] <= '0;
        cfg_data[ch] <= '0;
      end
    end else begin
      sl_xferack   <= take;
      adc0_rst_req <= 1'b0;  // pulses fall back after one cycle
      adc1_rst_req <= 1'b0;
      adc0_psen    <= 1'b0;
      adc1_psen    <= 1'b0;
      start_q      <= 2'b00;
      clear_q      <= 2'b00;
      if (take) begin
        rd_idx <= idx;  // readback select held through the acknowledge
      end
      if (wr_take && (idx == adc5g_pkg::REG_CTRL)) begin
        if (opb_be[3]) begin
          adc0_rst_req <= opb_dbus[31];
          adc1_rst_req <= opb_dbus[30];
        end
        if (opb_be[1]) begin
          adc0_psen     <= opb_dbus[15];
          adc0_psincdec <= opb_dbus[14];
          adc1_psen     <= opb_dbus[11];
          adc1_psincdec <= opb_dbus[10];
        end
      end
      for (int ch = 0; ch < 2; ch++) begin
        if (wr_cfg[ch]) begin
          if (opb_be[3]) begin
            start_q[ch] <= opb_dbus[31];
            clear_q[ch] <= opb_dbus[30];
          end
          if (opb_be[2]) begin
            cfg_addr[ch] <= opb_dbus[16:23];
          end
          if (opb_be[1]) begin
            cfg_data[ch][7:0] <= opb_dbus[8:15];
          end
          if (opb_be[0]) begin
            cfg_data[ch][15:8] <= opb_dbus[0:7];
          end
        end
      end
    end
  end

  // frame carries the register contents as they stand after the start write
  assign cfg0_push  = start_q[0];
  assign cfg1_push  = start_q[1];
  assign cfg0_frame = {cfg_addr[0], cfg_data[0]};
  assign cfg1_frame = {cfg_addr[1], cfg_data[1]};
  assign ovf0_clear = clear_q[0];
  assign ovf1_clear = clear_q[1];

  // ==========================================================
  // readback
  // ==========================================================
  always_comb begin
    case (rd_idx)
      adc5g_pkg::REG_CTRL: rd_word = {2'b00, adc1_psdone, adc0_psdone, 6'b0,
                                      adc1_psincdec, adc1_psen, 2'b00,
                                      adc0_psincdec, adc0_psen, 16'b0};
      adc5g_pkg::REG_CFG0: rd_word = {cfg_data[0], cfg_addr[0], 6'b0, ovf0, !busy0};
      adc5g_pkg::REG_CFG1: rd_word = {cfg_data[1], cfg_addr[1], 6'b0, ovf1, !busy1};
      adc5g_pkg::REG_ZERO: rd_word = 32'b0;
      default:             rd_word = 32'b0;
    endcase
  end

  assign sl_dbus = sl_xferack ? rd_word : 32'b0;  // bus is OR-ed between slaves

endmodule

// File: adc5g_cmd_fifo.sv
// circular buffer of configuration frames between the register slave
// and the serializer, with sticky overflow flag
`timescale 1ns/1ns
`include "adc5g_macros.svh"

module adc5g_cmd_fifo #(
  parameter int DEPTH = `ADC5G_FIFO_DEPTH
) (
  input  logic                  OPB_Clk,
  input  logic                  arst_n,
  input  logic                  push,
  input  adc5g_pkg::spi_frame_t push_frame,
  input  logic                  pop,
  input  logic                  ovf_clear,
  output logic                  empty,
  output adc5g_pkg::spi_frame_t pop_frame,
  output logic                  overflow
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  adc5g_pkg::spi_frame_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign do_pop    = pop && !empty;
  assign do_push   = push && (!full || do_pop);  // a slot freed this cycle can be reused
  assign pop_frame = mem[rd_ptr];

  always_ff @(posedge OPB_Clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_frame;
    end
  end

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      if (push && !do_push) begin
        overflow <= 1'b1;  // dropped frame wins over a clear in the same cycle
      end else if (ovf_clear) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

// File: adc5g_spi_serializer.sv
// three-wire frame shifter for the ADC5G: bit time divider, frame FSM,
// shift register and mode pin
`timescale 1ns/1ns
`include "adc5g_macros.svh"

module adc5g_spi_serializer (
  input  logic                  OPB_Clk,
  input  logic                  arst_n,
  input  logic                  fifo_empty,
  input  adc5g_pkg::spi_frame_t fifo_frame,
  output logic                  fifo_pop,
  output logic                  busy,
  output logic                  sclk,
  output logic                  sdata,
  output logic                  modepin
);

  localparam int FRAME_BITS = $bits(adc5g_pkg::spi_frame_t);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CLKWAIT,
    ST_DATA,
    ST_FINISH
  } state_t;

  state_t                        state;
  logic [`ADC5G_SCLK_DIV_W-1:0]  div_cnt;
  logic [FRAME_BITS-1:0]         shift_q;
  logic [4:0]                    bit_cnt;
  logic                          bit_end;

  // ==========================================================
  // bit time divider
  // ==========================================================
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
    end else if (state == ST_IDLE) begin
      div_cnt <= '0;  // every frame starts on a clean bit boundary
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign bit_end = &div_cnt;
  assign sclk    = div_cnt[`ADC5G_SCLK_DIV_W-1];  // rises mid bit time

  // ==========================================================
  // frame FSM
  // ==========================================================
  assign fifo_pop = (state == ST_IDLE) && !fifo_empty;

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      shift_q <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (fifo_pop) begin
            shift_q <= fifo_frame;
            state   <= ST_CLKWAIT;
          end
        end
        ST_CLKWAIT: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (bit_end) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};  // empties to zero by the end
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 5'(FRAME_BITS - 1)) begin
              state <= ST_FINISH;
            end
          end
        end
        ST_FINISH: begin
          if (bit_end) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign busy    = (state != ST_IDLE);
  assign sdata   = shift_q[FRAME_BITS-1];
  assign modepin = (state != ST_DATA);  // low only while data bits shift

endmodule

// File: adc5g_reset_gen.sv
// ADC pad reset register and clock manager reset hold counter
`timescale 1ns/1ns
`include "adc5g_macros.svh"

module adc5g_reset_gen (
  input  logic OPB_Clk,
  input  logic arst_n,
  input  logic rst_req,
  output logic adc_reset,
  output logic dcm_reset
);

  logic [`ADC5G_RST_HOLD_W-1:0] hold_cnt;

  // pad flop gives the ADC a clean registered pulse
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_reset <= 1'b0;
    end else begin
      adc_reset <= rst_req;
    end
  end

  // hold starts full so the clock manager stays in reset after power up
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      hold_cnt <= '1;
    end else if (rst_req) begin
      hold_cnt <= '1;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign dcm_reset = (hold_cnt != '0);

endmodule

// File: opb_adc5g_controller.sv
// top level of the two-channel ADC5G controller: register slave, and per
// channel a frame buffer, serializer and reset generator
`timescale 1ns/1ns

module opb_adc5g_controller (
  input  logic        OPB_Clk,
  input  logic        arst_n,
  input  logic [0:31] opb_abus,
  input  logic [0:3]  opb_be,
  input  logic [0:31] opb_dbus,
  input  logic        opb_rnw,
  input  logic        opb_select,
  output logic [0:31] sl_dbus,
  output logic        sl_xferack,

  output logic        adc0_adc3wire_clk,
  output logic        adc0_adc3wire_data,
  output logic        adc0_modepin,
  output logic        adc0_reset,
  output logic        adc0_dcm_reset,
  output logic        adc0_psclk,
  output logic        adc0_psen,
  output logic        adc0_psincdec,
  input  logic        adc0_psdone,

  output logic        adc1_adc3wire_clk,
  output logic        adc1_adc3wire_data,
  output logic        adc1_modepin,
  output logic        adc1_reset,
  output logic        adc1_dcm_reset,
  output logic        adc1_psclk,
  output logic        adc1_psen,
  output logic        adc1_psincdec,
  input  logic        adc1_psdone
);

  logic                  adc0_rst_req;
  logic                  adc1_rst_req;
  logic                  cfg0_push;
  logic                  cfg1_push;
  adc5g_pkg::spi_frame_t cfg0_frame;
  adc5g_pkg::spi_frame_t cfg1_frame;
  logic                  ovf0_clear;
  logic                  ovf1_clear;
  logic                  ovf0;
  logic                  ovf1;
  logic                  fifo0_empty;
  logic                  fifo1_empty;
  adc5g_pkg::spi_frame_t fifo0_frame;
  adc5g_pkg::spi_frame_t fifo1_frame;
  logic                  fifo0_pop;
  logic                  fifo1_pop;
  logic                  ser0_busy;
  logic                  ser1_busy;
  logic                  busy0;
  logic                  busy1;

  assign busy0 = !fifo0_empty || ser0_busy;  // done only when nothing is left to send
  assign busy1 = !fifo1_empty || ser1_busy;

  assign adc0_psclk = OPB_Clk;
  assign adc1_psclk = OPB_Clk;

  // ==========================================================
  // register slave
  // ==========================================================
  opb_adc5g_regs i_regs (
    .OPB_Clk       (OPB_Clk),
    .arst_n        (arst_n),
    .opb_abus      (opb_abus),
    .opb_be        (opb_be),
    .opb_dbus      (opb_dbus),
    .opb_rnw       (opb_rnw),
    .opb_select    (opb_select),
    .adc0_psdone   (adc0_psdone),
    .adc1_psdone   (adc1_psdone),
    .busy0         (busy0),
    .busy1         (busy1),
    .ovf0          (ovf0),
    .ovf1          (ovf1),
    .sl_dbus       (sl_dbus),
    .sl_xferack    (sl_xferack),
    .adc0_rst_req  (adc0_rst_req),
    .adc1_rst_req  (adc1_rst_req),
    .adc0_psen     (adc0_psen),
    .adc0_psincdec (adc0_psincdec),
    .adc1_psen     (adc1_psen),
    .adc1_psincdec (adc1_psincdec),
    .cfg0_push     (cfg0_push),
    .cfg0_frame    (cfg0_frame),
    .cfg1_push     (cfg1_push),
    .cfg1_frame    (cfg1_frame),
    .ovf0_clear    (ovf0_clear),
    .ovf1_clear    (ovf1_clear)
  );

  // ==========================================================
  // channel 0
  // ==========================================================
  adc5g_cmd_fifo i_fifo0 (
    .OPB_Clk    (OPB_Clk),
    .arst_n     (arst_n),
    .push       (cfg0_push),
    .push_frame (cfg0_frame),
    .pop        (fifo0_pop),
    .ovf_clear  (ovf0_clear),
    .empty      (fifo0_empty),
    .pop_frame  (fifo0_frame),
    .overflow   (ovf0)
  );

  adc5g_spi_serializer i_ser0 (
    .OPB_Clk    (OPB_Clk),
    .arst_n     (arst_n),
    .fifo_empty (fifo0_empty),
    .fifo_frame (fifo0_frame),
    .fifo_pop   (fifo0_pop),
    .busy       (ser0_busy),
    .sclk       (adc0_adc3wire_clk),
    .sdata      (adc0_adc3wire_data),
    .modepin    (adc0_modepin)
  );

  adc5g_reset_gen i_rst0 (
    .OPB_Clk   (OPB_Clk),
    .arst_n    (arst_n),
    .rst_req   (adc0_rst_req),
    .adc_reset (adc0_reset),
    .dcm_reset (adc0_dcm_reset)
  );

  // ==========================================================
  // channel 1
  // ==========================================================
  adc5g_cmd_fifo i_fifo1 (
    .OPB_Clk    (OPB_Clk),
    .arst_n     (arst_n),
    .push       (cfg1_push),
    .push_frame (cfg1_frame),
    .pop        (fifo1_pop),
    .ovf_clear  (ovf1_clear),
    .empty      (fifo1_empty),
    .pop_frame  (fifo1_frame),
    .overflow   (ovf1)
  );

  adc5g_spi_serializer i_ser1 (
    .OPB_Clk    (OPB_Clk),
    .arst_n     (arst_n),
    .fifo_empty (fifo1_empty),
    .fifo_frame (fifo1_frame),
    .fifo_pop   (fifo1_pop),
    .busy       (ser1_busy),
    .sclk       (adc1_adc3wire_clk),
    .sdata      (adc1_adc3wire_data),
    .modepin    (adc1_modepin)
  );

  adc5g_reset_gen i_rst1 (
    .OPB_Clk   (OPB_Clk),
    .arst_n    (arst_n),
    .rst_req   (adc1_rst_req),
    .adc_reset (adc1_reset),
    .dcm_reset (adc1_dcm_reset)
  );

endmodule

// File: tb_opb_adc5g_controller.sv
// testbench for the two-channel ADC5G controller with OPB bus tasks, serial
// frame monitors, pattern replay and directed reset and phase shift checks
`timescale 1ns/1ns
`include "adc5g_macros.svh"

module tb_opb_adc5g_controller;

  localparam int PAT_LINES     = 64;
  localparam int ACK_TIMEOUT   = 16;
  localparam int FRAME_TIMEOUT = 4000;

  logic        OPB_Clk = 1'b0;
  logic        arst_n;
  logic [31:0] opb_abus;
  logic [3:0]  opb_be;
  logic [31:0] opb_dbus;
  logic        opb_rnw;
  logic        opb_select;
  logic [1:0]  psdone;
  wire  [31:0] sl_dbus;
  wire         sl_xferack;
  wire  [1:0]  sclk;
  wire  [1:0]  sdata;
  wire  [1:0]  modepin;
  wire  [1:0]  adc_reset;
  wire  [1:0]  dcm_reset;
  wire  [1:0]  psclk;
  wire  [1:0]  psen;
  wire  [1:0]  psincdec;

  logic [31:0] pat [0:5*PAT_LINES-1];
  logic [23:0] frames0 [$];
  logic [23:0] frames1 [$];
  logic [23:0] shift0 = '0;
  logic [23:0] shift1 = '0;
  int          nbits0 = 0;
  int          nbits1 = 0;
  int          rst_hi [2] = '{0, 0};
  int          dcm_hi [2] = '{0, 0};
  int          psen_hi [2] = '{0, 0};
  int          ack_cnt = 0;
  int          cycle = 0;
  int          accesses = 0;
  int          checks = 0;
  int          errors = 0;
  integer      seed = 32'h27ac508a;

  always #20 OPB_Clk = ~OPB_Clk;

  opb_adc5g_controller i_dut (
    .OPB_Clk (OPB_Clk), .arst_n (arst_n), .opb_abus (opb_abus), .opb_be (opb_be),
    .opb_dbus (opb_dbus), .opb_rnw (opb_rnw), .opb_select (opb_select),
    .sl_dbus (sl_dbus), .sl_xferack (sl_xferack),
    .adc0_adc3wire_clk (sclk[0]), .adc0_adc3wire_data (sdata[0]),
    .adc0_modepin (modepin[0]), .adc0_reset (adc_reset[0]), .adc0_dcm_reset (dcm_reset[0]),
    .adc0_psclk (psclk[0]), .adc0_psen (psen[0]), .adc0_psincdec (psincdec[0]),
    .adc0_psdone (psdone[0]),
    .adc1_adc3wire_clk (sclk[1]), .adc1_adc3wire_data (sdata[1]),
    .adc1_modepin (modepin[1]), .adc1_reset (adc_reset[1]), .adc1_dcm_reset (dcm_reset[1]),
    .adc1_psclk (psclk[1]), .adc1_psen (psen[1]), .adc1_psincdec (psincdec[1]),
    .adc1_psdone (psdone[1])
  );

  // ==========================================================
  // monitors
  // ==========================================================
  always @(negedge OPB_Clk) begin
    cycle++;
    ack_cnt += sl_xferack;  // a one-cycle acknowledge counts once
    for (int ch = 0; ch < 2; ch++) begin
      rst_hi[ch]  += adc_reset[ch];
      dcm_hi[ch]  += dcm_reset[ch];
      psen_hi[ch] += psen[ch];
    end
  end

  always @(posedge sclk[0]) begin
    if (!modepin[0]) begin
      shift0 = {shift0[22:0], sdata[0]};  // first bit in ends up as the msb
      nbits0++;
      if (nbits0 == 24) begin
        frames0.push_back(shift0);
        nbits0 = 0;
      end
    end
  end

  always @(posedge sclk[1]) begin
    if (!modepin[1]) begin
      shift1 = {shift1[22:0], sdata[1]};
      nbits1++;
      if (nbits1 == 24) begin
        frames1.push_back(shift1);
        nbits1 = 0;
      end
    end
  end

  // ==========================================================
  // checks and bus tasks
  // ==========================================================
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  // psdone sits in bus bits 2 and 3 of register 0
  function automatic logic [31:0] psdone_word();
    return {2'b00, psdone[1], psdone[0], 28'b0};
  endfunction

  task automatic drive_psdone();
    logic [31:0] r;
    r = $random(seed);
    psdone = r[1:0];
  endtask

  // called on a falling edge, returns on the falling edge that saw the acknowledge
  task automatic bus_access(input logic rnw, input logic [1:0] idx, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   n;
    logic acked;
    rdata      = '0;
    acked      = 1'b0;
    n          = 0;
    opb_abus   = `ADC5G_BASEADDR + {28'h0, idx, 2'b00};
    opb_rnw    = rnw;
    opb_be     = be;
    opb_dbus   = rnw ? 32'h0 : wdata;
    opb_select = 1'b1;
    while (!acked && n < ACK_TIMEOUT) begin
      @(negedge OPB_Clk);
      n++;
      if (sl_xferack) begin
        acked = 1'b1;
        rdata = sl_dbus;
      end else begin
        check_value("bus data without acknowledge", 32'h0, sl_dbus);
      end
    end
    opb_select = 1'b0;
    opb_rnw    = 1'b1;
    opb_be     = '0;
    opb_dbus   = '0;
    accesses++;
    if (!acked) begin
      report_failure($sformatf("no bus acknowledge for register %0d within %0d cycles",
                               idx, ACK_TIMEOUT));
    end
  endtask

  task automatic expect_frame(input int ch, input logic [23:0] expected, input string name);
    int          n;
    logic [23:0] got;
    n = 0;
    while (((ch == 0) ? frames0.size() : frames1.size()) == 0 && n < FRAME_TIMEOUT) begin
      @(negedge OPB_Clk);
      n++;
    end
    if (((ch == 0) ? frames0.size() : frames1.size()) == 0) begin
      report_failure($sformatf("no serial frame on channel %0d within %0d cycles",
                               ch, FRAME_TIMEOUT));
    end else begin
      if (ch == 0) begin
        got = frames0.pop_front();
      end else begin
        got = frames1.pop_front();
      end
      check_value(name, {8'h00, expected}, {8'h00, got});
    end
  endtask

  task automatic wait_done(input logic [1:0] idx, input int frames);
    int          start;
    logic [31:0] rd;
    start = cycle;
    rd    = '0;
    while (rd[0] !== 1'b1 && cycle - start < FRAME_TIMEOUT * frames) begin
      bus_access(1'b1, idx, 4'h0, 32'h0, rd);
    end
    if (rd[0] !== 1'b1) begin
      report_failure($sformatf("register %0d never reported done", idx));
    end
  endtask

  // ==========================================================
  // test sequences
  // ==========================================================
  task automatic check_reset_state();
    int n;
    int fall [2];
    fall = '{-1, -1};
    n    = 0;
    check_value("dcm reset after release", 32'h3, dcm_reset);
    check_value("mode pins after reset", 32'h3, modepin);
    check_value("serial clock and data after reset", 32'h0, {sclk, sdata});
    check_value("pulses after reset", 32'h0, {adc_reset, psen, sl_xferack});
    while ((fall[0] < 0 || fall[1] < 0) && n < 300) begin
      @(negedge OPB_Clk);
      n++;
      for (int ch = 0; ch < 2; ch++) begin
        if (fall[ch] < 0 && !dcm_reset[ch]) begin
          fall[ch] = n;
        end
      end
    end
    for (int ch = 0; ch < 2; ch++) begin
      if (fall[ch] < 0) begin
        report_failure($sformatf("dcm reset %0d did not fall after power-up reset", ch));
      end else begin
        check_value($sformatf("dcm%0d hold after release", ch), 32'd255, fall[ch]);
      end
    end
  endtask

  task automatic run_patterns();
    int          line;
    logic [31:0] op;
    logic [31:0] idx;
    logic [31:0] expected;
    logic [31:0] rd;
    line = 0;
    while (line < PAT_LINES && !$isunknown(pat[5*line]) && pat[5*line] != 32'hF) begin
      op       = pat[5*line];
      idx      = pat[5*line+1];
      expected = pat[5*line+4];
      case (op)
        0: bus_access(1'b0, idx[1:0], pat[5*line+2][3:0], pat[5*line+3], rd);
        1: begin
          if (idx == 0) begin
            drive_psdone();
            expected = expected | psdone_word();
          end
          bus_access(1'b1, idx[1:0], 4'h0, 32'h0, rd);
          check_value($sformatf("pattern %0d read reg %0d", line, idx), expected, rd);
        end
        2: expect_frame(idx - 1, expected[23:0], $sformatf("pattern %0d frame", line));
        3: wait_done(idx[1:0], pat[5*line+3]);
        default: report_failure($sformatf("unknown operation in pattern line %0d", line));
      endcase
      line++;
    end
  endtask

  task automatic check_reset_request(input int ch);
    int          rst_snap [2];
    int          dcm_snap [2];
    logic [31:0] rd;
    rst_snap = rst_hi;
    dcm_snap = dcm_hi;
    bus_access(1'b0, 2'd0, 4'h1, (ch == 0) ? 32'h1 : 32'h2, rd);
    repeat (300) @(negedge OPB_Clk);  // covers the whole 255 cycle hold
    for (int k = 0; k < 2; k++) begin
      check_value($sformatf("adc%0d reset pulse cycles", k), (k == ch) ? 1 : 0,
                  rst_hi[k] - rst_snap[k]);
      check_value($sformatf("dcm%0d reset hold cycles", k), (k == ch) ? 255 : 0,
                  dcm_hi[k] - dcm_snap[k]);
    end
  endtask

  task automatic check_phase_shift(input logic [31:0] wdata, input logic [1:0] psen_exp,
                                   input logic [1:0] incdec_exp);
    int          psen_snap [2];
    logic [31:0] rd;
    logic [31:0] expected;
    psen_snap = psen_hi;
    bus_access(1'b0, 2'd0, 4'h4, wdata, rd);
    repeat (8) @(negedge OPB_Clk);
    for (int k = 0; k < 2; k++) begin
      check_value($sformatf("psen%0d pulse cycles", k), psen_exp[k], psen_hi[k] - psen_snap[k]);
      check_value($sformatf("psincdec%0d level", k), incdec_exp[k], psincdec[k]);
    end
    for (int r = 0; r < 3; r++) begin
      drive_psdone();
      expected = psdone_word() | (32'(incdec_exp[1]) << 21) | (32'(incdec_exp[0]) << 17);
      bus_access(1'b1, 2'd0, 4'h0, 32'h0, rd);
      check_value("register 0 readback", expected, rd);
    end
  endtask

  // phase shift clocks are the bus clock itself
  task automatic compare_psclk();
    @(negedge OPB_Clk);
    #10;
    check_value("psclk low phase", 32'h0, psclk);
    #20;
    check_value("psclk high phase", 32'h3, psclk);
    @(negedge OPB_Clk);
  endtask

  initial begin
    arst_n     = 1'b0;
    opb_abus   = '0;
    opb_be     = '0;
    opb_dbus   = '0;
    opb_rnw    = 1'b1;
    opb_select = 1'b0;
    psdone     = '0;
    $readmemh("adc5g_patterns.txt", pat);
    repeat (2) @(negedge OPB_Clk);
    arst_n = 1'b1;
    check_reset_state();
    run_patterns();
    check_reset_request(0);
    check_reset_request(1);
    check_phase_shift(32'h0023_0000, 2'b01, 2'b11);
    check_phase_shift(32'h0010_0000, 2'b10, 2'b00);
    compare_psclk();
    check_value("acknowledge count", accesses, ack_cnt);
    check_value("channel 0 extra frames", 32'h0, frames0.size());
    check_value("channel 1 extra frames", 32'h0, frames1.size());
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: adc5g_patterns.txt
// op reg be data expected: op 0 write, 1 read and compare, 2 expect serial frame,
// 3 wait for done (data is frames pending), f ends the list; expected is a word or frame
1 1 0 00000000 00000001
1 2 0 00000000 00000001
1 0 0 00000000 00000000
0 1 F 12345600 00000000
0 1 4 00AB0000 00000000
0 1 8 77000000 00000000
1 1 0 00000000 77AB5601
0 2 2 00009900 00000000
1 2 0 00000000 00009901
0 3 F FFFFFFFF 00000000
1 3 0 00000000 00000000
0 1 F A5C33C01 00000000
1 1 0 00000000 A5C33C00
2 1 0 00000000 003CA5C3
3 1 0 00000001 00000000
1 1 0 00000000 A5C33C01
0 2 F C0DE4201 00000000
1 2 0 00000000 C0DE4200
2 2 0 00000000 0042C0DE
3 2 0 00000001 00000000
1 2 0 00000000 C0DE4201
0 1 F 11110101 00000000
0 1 F 22220201 00000000
0 1 F 33330301 00000000
0 1 F 44440401 00000000
0 1 F 55550501 00000000
0 1 F 66660601 00000000
1 1 0 00000000 66660602
2 1 0 00000000 00011111
2 1 0 00000000 00022222
2 1 0 00000000 00033333
2 1 0 00000000 00044444
2 1 0 00000000 00055555
3 1 0 00000001 00000000
1 1 0 00000000 66660603
0 1 1 00000002 00000000
1 1 0 00000000 66660601
F 0 0 00000000 00000000

// File: sim.f
+incdir+.
adc5g_pkg.sv
opb_adc5g_regs.sv
adc5g_cmd_fifo.sv
adc5g_spi_serializer.sv
adc5g_reset_gen.sv
opb_adc5g_controller.sv
tb_opb_adc5g_controller.sv

// File: Bender.yml
package:
  name: opb_adc5g_controller

sources:
  - include_dirs:
      - .
    files:
      - adc5g_pkg.sv
      - opb_adc5g_regs.sv
      - adc5g_cmd_fifo.sv
      - adc5g_spi_serializer.sv
      - adc5g_reset_gen.sv
      - opb_adc5g_controller.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_opb_adc5g_controller.sv
